// File: ir_codes_pkg.sv
package ir_codes_pkg;

	typedef logic [31:0] frame_t; // full frame as delivered by the receiver
	typedef logic [15:0] half_code_t; // custom code or key code
	typedef logic [2:0]  remote_t;
	typedef logic [3:0]  key_t;

	localparam int num_remotes = 8;
	localparam int num_keys    = 16;

	// custom codes sit in the low half of the frame
	localparam half_code_t remote_codes [num_remotes] = '{
		16'h7F80,
		16'h6F90,
		16'h5FA0,
		16'h4FB0,
		16'h3FC0,
		16'h2FD0,
		16'h1FE0,
		16'h0FF0
	};

	// key codes sit in the high half, NEC style command byte plus its inverse
	localparam half_code_t key_codes [num_remotes][num_keys] = '{
		// remote 0
		'{16'hFF00, 16'hFE01, 16'hFD02, 16'hFC03, 16'hFB04, 16'hFA05, 16'hF906, 16'hF807,
		  16'hF708, 16'hF609, 16'hF50A, 16'hF40B, 16'hF30C, 16'hF20D, 16'hF10E, 16'hF00F},
		// remote 1
		'{16'hEF10, 16'hEE11, 16'hED12, 16'hEC13, 16'hEB14, 16'hEA15, 16'hE916, 16'hE817,
		  16'hE718, 16'hE619, 16'hE51A, 16'hE41B, 16'hE31C, 16'hE21D, 16'hE11E, 16'hE01F},
		// remote 2
		'{16'hDF20, 16'hDE21, 16'hDD22, 16'hDC23, 16'hDB24, 16'hDA25, 16'hD926, 16'hD827,
		  16'hD728, 16'hD629, 16'hD52A, 16'hD42B, 16'hD32C, 16'hD22D, 16'hD12E, 16'hD02F},
		// remote 3
		'{16'hCF30, 16'hCE31, 16'hCD32, 16'hCC33, 16'hCB34, 16'hCA35, 16'hC936, 16'hC837,
		  16'hC738, 16'hC639, 16'hC53A, 16'hC43B, 16'hC33C, 16'hC23D, 16'hC13E, 16'hC03F},
		// remote 4
		'{16'hBF40, 16'hBE41, 16'hBD42, 16'hBC43, 16'hBB44, 16'hBA45, 16'hB946, 16'hB847,
		  16'hB748, 16'hB649, 16'hB54A, 16'hB44B, 16'hB34C, 16'hB24D, 16'hB14E, 16'hB04F},
		// remote 5
		'{16'hAF50, 16'hAE51, 16'hAD52, 16'hAC53, 16'hAB54, 16'hAA55, 16'hA956, 16'hA857,
		  16'hA758, 16'hA659, 16'hA55A, 16'hA45B, 16'hA35C, 16'hA25D, 16'hA15E, 16'hA05F},
		// remote 6
		'{16'h9F60, 16'h9E61, 16'h9D62, 16'h9C63, 16'h9B64, 16'h9A65, 16'h9966, 16'h9867,
		  16'h9768, 16'h9669, 16'h956A, 16'h946B, 16'h936C, 16'h926D, 16'h916E, 16'h906F},
		// remote 7
		'{16'h8F70, 16'h8E71, 16'h8D72, 16'h8C73, 16'h8B74, 16'h8A75, 16'h8976, 16'h8877,
		  16'h8778, 16'h8679, 16'h857A, 16'h847B, 16'h837C, 16'h827D, 16'h817E, 16'h807F}
	};

endpackage

// File: ir_bus_pkg.sv
package ir_bus_pkg;

	typedef logic [31:0] word_t; // bus address or data

	localparam word_t decoder_addr = 32'h0000_4010;

	// value after reset and after every selected read
	localparam word_t invalid_word = 32'h8000_0000;

	// access format of the reading instruction, 3 falls back to byte
	typedef enum logic [1:0]
	{
		fmt_byte = 2'd0,
		fmt_half = 2'd1,
		fmt_word = 2'd2
	} access_fmt_t;

	// result word layout
	localparam int invalid_bit     = 31;
	localparam int key_lsb         = 18; // key index in 21:18
	localparam int remote_lsb_byte = 0;
	localparam int remote_lsb_half = 1;
	localparam int remote_lsb_word = 2;

	// settling window after data_ready rises
	typedef logic [7:0] win_count_t;

	localparam win_count_t win_begin = 8'd48; // capture point
	localparam win_count_t win_end   = 8'd58; // last count before wrap

endpackage

// File: ir_code_decode.sv
`timescale 1ns/1ps

module ir_code_decode
(
	input  ir_codes_pkg::frame_t  code,
	output ir_codes_pkg::remote_t remote,
	output ir_codes_pkg::key_t    key,
	output logic                  invalid
);

	ir_codes_pkg::half_code_t lo_half; // custom code
	ir_codes_pkg::half_code_t hi_half; // key code

	logic remote_hit;
	logic key_hit;

	assign lo_half = code[15:0];
	assign hi_half = code[31:16];

	// remote lookup, the custom codes are all distinct so at most one hit
	always_comb
	begin
		remote_hit = 1'b0;
		remote     = '0;
		for (int r = 0; r < ir_codes_pkg::num_remotes; r++)
		begin
			if (lo_half == ir_codes_pkg::remote_codes[r])
			begin
				remote_hit = 1'b1;
				remote     = ir_codes_pkg::remote_t'(r);
			end
		end
	end

	// key lookup in the row of the matched remote only
	always_comb
	begin
		key_hit = 1'b0;
		key     = '0;
		if (remote_hit)
		begin
			for (int k = 0; k < ir_codes_pkg::num_keys; k++)
			begin
				if (hi_half == ir_codes_pkg::key_codes[remote][k])
				begin
					key_hit = 1'b1;
					key     = ir_codes_pkg::key_t'(k);
				end
			end
		end
	end

	assign invalid = !key_hit; // a key hit implies a remote hit

	// unknown remote must come out as the plain invalid word downstream
	always_comb
	begin
		if (!remote_hit)
		begin
			assert #0 (invalid && remote == '0 && key == '0)
				else $error("unmatched remote with nonzero indices");
		end
	end

endmodule

// File: ready_window.sv
`timescale 1ns/1ps

module ready_window
(
	input  logic iCLK,
	input  logic rst_n,
	input  logic data_ready,
	output logic capture
);

	ir_bus_pkg::win_count_t count;

	// settling counter, wraps so a held frame is taken again each window
	always_ff @(posedge iCLK)
	begin
		if (!rst_n)
		begin
			count <= '0;
		end
		else if (!data_ready)
		begin
			count <= '0; // idle between frames
		end
		else if (count < ir_bus_pkg::win_end)
		begin
			count <= count + ir_bus_pkg::win_count_t'(1);
		end
		else
		begin
			count <= '0;
		end
	end

	// one pulse per window, on the edge after the count hits win_begin
	always_ff @(posedge iCLK)
	begin
		if (!rst_n)
		begin
			capture <= 1'b0;
		end
		else
		begin
			capture <= data_ready && (count == ir_bus_pkg::win_begin);
		end
	end

	// strobe must stay a single cycle wide across the wrap too
	a_capture_single : assert property (
		@(posedge iCLK) disable iff (!rst_n)
		capture |=> !capture
	) else $error("capture high on two consecutive cycles");

endmodule

// File: ir_result_reg.sv
`timescale 1ns/1ps

module ir_result_reg
(
	input  logic                    iCLK,
	input  logic                    rst_n,
	input  logic                    capture,
	input  ir_codes_pkg::remote_t   remote,
	input  ir_codes_pkg::key_t      key,
	input  logic                    invalid,
	input  ir_bus_pkg::access_fmt_t fmt,
	input  logic                    read_en,
	input  ir_bus_pkg::word_t       addr,
	output ir_bus_pkg::word_t       read_data
);

	localparam int remote_w = $bits(ir_codes_pkg::remote_t);
	localparam int key_w    = $bits(ir_codes_pkg::key_t);

	ir_bus_pkg::word_t packed_word;
	ir_bus_pkg::word_t result;

	logic read_sel;

	// pack the decode result, the remote index moves with the access format
	always_comb
	begin
		packed_word                                   = '0;
		packed_word[ir_bus_pkg::invalid_bit]          = invalid;
		packed_word[ir_bus_pkg::key_lsb +: key_w]     = key; // zero unless valid
		case (fmt)
			ir_bus_pkg::fmt_half:
				packed_word[ir_bus_pkg::remote_lsb_half +: remote_w] = remote;
			ir_bus_pkg::fmt_word:
				packed_word[ir_bus_pkg::remote_lsb_word +: remote_w] = remote;
			default:
				packed_word[ir_bus_pkg::remote_lsb_byte +: remote_w] = remote; // byte and 3
		endcase
	end

	assign read_sel = read_en && (addr == ir_bus_pkg::decoder_addr);

	// clear on read wins over a capture in the same cycle
	always_ff @(posedge iCLK)
	begin
		if (!rst_n)
		begin
			result <= ir_bus_pkg::invalid_word;
		end
		else if (read_sel)
		begin
			result <= ir_bus_pkg::invalid_word;
		end
		else if (capture)
		begin
			result <= packed_word; // overwrites an unread result
		end
	end

	assign read_data = read_sel ? result : '0;

	// shared read bus, the decoder only drives it when addressed
	a_idle_zero : assert property (
		@(posedge iCLK) disable iff (!rst_n)
		!read_sel |-> (read_data == '0)
	) else $error("read_data nonzero outside a selected read");

endmodule

// File: ir_remote_decoder.sv
`timescale 1ns/1ps

module ir_remote_decoder
(
	input  logic                    iCLK,
	input  logic                    rst_n,
	input  ir_codes_pkg::frame_t    code,
	input  logic                    data_ready,
	input  logic                    read_en,
	input  ir_bus_pkg::word_t       addr,
	input  ir_bus_pkg::access_fmt_t fmt,
	output ir_bus_pkg::word_t       read_data
);

	ir_codes_pkg::remote_t remote;
	ir_codes_pkg::key_t    key;
	logic                  invalid;
	logic                  capture;

	// frame lookup, zero latency
	ir_code_decode i_ir_code_decode
	(
		.code    (code),
		.remote  (remote),
		.key     (key),
		.invalid (invalid)
	);

	// waits for the frame to settle before taking it
	ready_window i_ready_window
	(
		.iCLK       (iCLK),
		.rst_n      (rst_n),
		.data_ready (data_ready),
		.capture    (capture)
	);

	ir_result_reg i_ir_result_reg
	(
		.iCLK      (iCLK),
		.rst_n     (rst_n),
		.capture   (capture),
		.remote    (remote),
		.key       (key),
		.invalid   (invalid),
		.fmt       (fmt),
		.read_en   (read_en),
		.addr      (addr),
		.read_data (read_data)
	);

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen
(
	output logic iCLK,
	output logic rst_n
);

	localparam int half_period = 20; // 40 ns clock
	localparam int reset_cycles = 3;

	initial
	begin
		iCLK = 1'b0;
		forever #half_period iCLK = ~iCLK;
	end

	// released on a falling edge so the DUT sees a clean synchronous release
	initial
	begin
		rst_n = 1'b0;
		repeat (reset_cycles) @(posedge iCLK);
		@(negedge iCLK);
		rst_n = 1'b1;
	end

endmodule

// File: tb_ir_remote_decoder.sv
`timescale 1ns/1ps

module tb_ir_remote_decoder;

	localparam int poll_limit     = 100; // reads before a poll gives up
	localparam int reset_limit    = 20;
	localparam int settle         = 5; // read_data is combinational, sampled after this
	localparam int run_limit      = 1000000;
	localparam int valid_rounds   = 20;
	localparam logic [31:0] seed  = 32'had5e51b9;

	logic                    iCLK;
	logic                    rst_n;
	ir_codes_pkg::frame_t    code;
	logic                    data_ready;
	logic                    read_en;
	ir_bus_pkg::word_t       addr;
	ir_bus_pkg::access_fmt_t fmt;
	ir_bus_pkg::word_t       read_data;

	logic [31:0] lfsr_state;
	int          checks;
	int          errors;
	int          timeouts;

	tb_clock_gen i_tb_clock_gen
	(
		.iCLK  (iCLK),
		.rst_n (rst_n)
	);

	ir_remote_decoder i_ir_remote_decoder
	(
		.iCLK       (iCLK),
		.rst_n      (rst_n),
		.code       (code),
		.data_ready (data_ready),
		.read_en    (read_en),
		.addr       (addr),
		.fmt        (fmt),
		.read_data  (read_data)
	);

	// x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic fb;
		fb = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], fb};
	endfunction

	task automatic random_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			v          = {v[30:0], lfsr_state[0]}; // one step per bit
		end
	endtask

	// result word as the layout rule describes it
	function automatic ir_bus_pkg::word_t expected_word
	(
		input bit         remote_known,
		input bit         key_known,
		input int         r,
		input int         k,
		input logic [1:0] f
	);
		ir_bus_pkg::word_t w;
		int                pos;
		if (!remote_known)
			return ir_bus_pkg::invalid_word;
		case (f)
			2'd1:    pos = ir_bus_pkg::remote_lsb_half;
			2'd2:    pos = ir_bus_pkg::remote_lsb_word;
			default: pos = ir_bus_pkg::remote_lsb_byte; // 3 reads as a byte access
		endcase
		w = '0;
		if (key_known)
			w = w | (ir_bus_pkg::word_t'(k) << ir_bus_pkg::key_lsb);
		else
			w[ir_bus_pkg::invalid_bit] = 1'b1;
		w = w | (ir_bus_pkg::word_t'(r) << pos);
		return w;
	endfunction

	task automatic check_value
	(
		input ir_bus_pkg::word_t actual,
		input ir_bus_pkg::word_t expected,
		input string             what
	);
		checks++;
		if (actual !== expected)
		begin
			errors++;
			$display("ERR %0t ns: %s, read %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(negedge iCLK);
	endtask

	// one-cycle read strobe
	task automatic bus_read(input ir_bus_pkg::word_t a, output ir_bus_pkg::word_t data);
		@(negedge iCLK);
		read_en = 1'b1;
		addr    = a;
		#settle;
		data = read_data;
		@(negedge iCLK);
		read_en = 1'b0;
		addr    = '0;
	endtask

	task automatic send_frame(input ir_codes_pkg::frame_t c, input logic [1:0] f, input int hold);
		@(negedge iCLK);
		code       = c;
		fmt        = ir_bus_pkg::access_fmt_t'(f);
		data_ready = 1'b1;
		repeat (hold) @(negedge iCLK);
		data_ready = 1'b0; // code stays put, only the level drops
	endtask

	task automatic poll_result(output ir_bus_pkg::word_t data);
		int reads;
		bit found;
		reads = 0;
		found = 1'b0;
		data  = ir_bus_pkg::invalid_word;
		while (!found && reads < poll_limit)
		begin
			bus_read(ir_bus_pkg::decoder_addr, data);
			reads++;
			found = (data !== ir_bus_pkg::invalid_word);
		end
		if (!found)
		begin
			timeouts++;
			$display("timeout at %0t ns: no result after %0d reads", $time, poll_limit);
		end
	endtask

	task automatic test_reset();
		ir_bus_pkg::word_t data;
		bus_read(ir_bus_pkg::decoder_addr, data);
		check_value(data, ir_bus_pkg::invalid_word, "read after reset");
		bus_read(ir_bus_pkg::decoder_addr + 32'h4, data);
		check_value(data, '0, "read at another address");
	endtask

	task automatic test_valid_codes();
		logic [31:0]          r;
		logic [31:0]          k;
		logic [31:0]          f;
		ir_bus_pkg::word_t    data;
		ir_bus_pkg::word_t    exp;
		ir_codes_pkg::frame_t c;
		for (int i = 0; i < valid_rounds; i++)
		begin
			random_bits(3, r);
			random_bits(4, k);
			random_bits(2, f);
			c   = {ir_codes_pkg::key_codes[r][k], ir_codes_pkg::remote_codes[r]};
			exp = expected_word(1'b1, 1'b1, r, k, f[1:0]);
			send_frame(c, f[1:0], 52);
			poll_result(data);
			check_value(data, exp, $sformatf("remote %0d key %0d fmt %0d", r, k, f));
			bus_read(ir_bus_pkg::decoder_addr, data);
			check_value(data, ir_bus_pkg::invalid_word, "second read after a valid code");
		end
	endtask

	task automatic test_invalid_codes();
		ir_bus_pkg::word_t data;
		ir_bus_pkg::word_t exp;
		// remote 5 known, key half in no row
		exp = expected_word(1'b1, 1'b0, 5, 0, 2'd1);
		send_frame({16'h1234, ir_codes_pkg::remote_codes[5]}, 2'd1, 52);
		poll_result(data);
		check_value(data, exp, "unknown key, halfword access");
		bus_read(ir_bus_pkg::decoder_addr, data);
		check_value(data, ir_bus_pkg::invalid_word, "read after unknown key");
		exp = expected_word(1'b1, 1'b0, 2, 0, 2'd3);
		send_frame({16'h1234, ir_codes_pkg::remote_codes[2]}, 2'd3, 52);
		poll_result(data);
		check_value(data, exp, "unknown key, format 3");
		// unknown remote gives the plain invalid word, so no polling
		exp = expected_word(1'b0, 1'b0, 0, 0, 2'd2);
		send_frame({ir_codes_pkg::key_codes[2][3], 16'h1234}, 2'd2, 52);
		bus_read(ir_bus_pkg::decoder_addr, data);
		check_value(data, exp, "unknown remote");
	endtask

	task automatic test_short_pulse();
		ir_bus_pkg::word_t data;
		send_frame({ir_codes_pkg::key_codes[3][7], ir_codes_pkg::remote_codes[3]}, 2'd2, 30);
		wait_cycles(40); // past where a capture would have been
		bus_read(ir_bus_pkg::decoder_addr, data);
		check_value(data, ir_bus_pkg::invalid_word, "data_ready too short");
	endtask

	task automatic test_held_frame();
		ir_bus_pkg::word_t    data;
		ir_bus_pkg::word_t    exp;
		ir_codes_pkg::frame_t c;
		c   = {ir_codes_pkg::key_codes[6][9], ir_codes_pkg::remote_codes[6]};
		exp = expected_word(1'b1, 1'b1, 6, 9, 2'd2);
		fork
			send_frame(c, 2'd2, 130);
			begin
				wait_cycles(55); // first window done
				poll_result(data);
				check_value(data, exp, "held frame, first window");
				bus_read(ir_bus_pkg::decoder_addr, data);
				check_value(data, ir_bus_pkg::invalid_word, "held frame after clear");
				// reads land on even edges, the reload at edge 109 is not hit
				poll_result(data);
				check_value(data, exp, "held frame, next window");
			end
		join
	endtask

	initial
	begin
		int n;
		code       = '0;
		data_ready = 1'b0;
		read_en    = 1'b0;
		addr       = '0;
		fmt        = ir_bus_pkg::fmt_byte;
		lfsr_state = seed;
		checks     = 0;
		errors     = 0;
		timeouts   = 0;

		n = 0;
		while (rst_n !== 1'b1 && n < reset_limit)
		begin
			@(negedge iCLK);
			n++;
		end
		if (rst_n !== 1'b1)
		begin
			timeouts++;
			$display("timeout: reset was never released");
		end

		test_reset();
		test_valid_codes();
		test_invalid_codes();
		test_short_pulse();
		test_held_frame();

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0 && timeouts == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

	// whole run needs well under a millisecond
	initial
	begin
		#run_limit;
		$display("timeout: simulation did not finish within %0d ns", run_limit);
		$display("Test FAILED");
		$finish;
	end

endmodule

// File: verilog.f
ir_codes_pkg.sv
ir_bus_pkg.sv
ir_code_decode.sv
ready_window.sv
ir_result_reg.sv
ir_remote_decoder.sv
tb_clock_gen.sv
tb_ir_remote_decoder.sv
